/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_eeprom_master
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

/* byte_receiver.sv */
module byte_receiver (
    input logic CLK,
    input logic RESET,
    shift_if.rx link
);

    typedef enum logic {
        RX_IDLE,
        RX_BUSY
    } rx_state_e;

    rx_state_e  state;
    logic [3:0] bit_cnt;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state        <= RX_IDLE;
            bit_cnt      <= 4'd0;
            link.done    <= 1'b0;
            link.sda_low <= 1'b0;
        end
        else
        begin
            link.done <= 1'b0;
            case (state)
                RX_IDLE:
                begin
                    if (link.go)
                    begin
                        link.ack_bit <= link.tx_byte[0];  // level to answer with
                        link.sda_low <= 1'b0;
                        bit_cnt      <= 4'd0;
                        state        <= RX_BUSY;
                    end
                end
                RX_BUSY:
                begin
                    if (link.scl_fall)
                    begin
                        if (bit_cnt == eeprom_cfg_pkg::ACK_SLOT)
                        begin
                            link.sda_low <= (link.ack_bit == eeprom_cfg_pkg::ACK_LEVEL);
                        end
                        else if (bit_cnt == eeprom_cfg_pkg::ACK_SLOT + 4'd1)
                        begin
                            // ack clock over, hand the line back
                            link.sda_low <= 1'b0;
                            link.done    <= 1'b1;
                            state        <= RX_IDLE;
                        end
                    end
                    else if (link.scl_rise)
                    begin
                        if (bit_cnt < eeprom_cfg_pkg::ACK_SLOT)
                            link.rx_byte <= {link.rx_byte[6:0], link.sda};  // msb first
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

/* byte_transmitter.sv */
module byte_transmitter (
    input logic CLK,
    input logic RESET,
    shift_if.tx link
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_STOP,
        TX_BYTE
    } tx_state_e;

    tx_state_e             state;
    logic                  armed;     // a fall has been seen since go
    logic [3:0]            bit_cnt;
    eeprom_cfg_pkg::byte_t shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state        <= TX_IDLE;
            armed        <= 1'b0;
            bit_cnt      <= 4'd0;
            link.done    <= 1'b0;
            link.sda_low <= 1'b0;
        end
        else
        begin
            link.done <= 1'b0;
            case (state)
                TX_IDLE:
                begin
                    if (link.go)
                    begin
                        armed   <= 1'b0;
                        bit_cnt <= 4'd0;
                        shreg   <= link.tx_byte;
                        case (link.cmd)
                            serial_frame_pkg::CMD_START: state <= TX_START;
                            serial_frame_pkg::CMD_STOP:  state <= TX_STOP;
                            default:                     state <= TX_BYTE;
                        endcase
                    end
                end
                TX_START:
                begin
                    if (link.scl_fall)
                    begin
                        link.sda_low <= 1'b0;  // release while scl low
                        armed        <= 1'b1;
                    end
                    else if (link.scl_rise && armed)
                    begin
                        link.sda_low <= 1'b1;  // falling sda with scl high
                        link.done    <= 1'b1;
                        state        <= TX_IDLE;
                    end
                end
                TX_STOP:
                begin
                    if (link.scl_fall)
                    begin
                        link.sda_low <= 1'b1;
                        armed        <= 1'b1;
                    end
                    else if (link.scl_rise && armed)
                    begin
                        link.sda_low <= 1'b0;  // rising sda with scl high
                        link.done    <= 1'b1;
                        state        <= TX_IDLE;
                    end
                end
                TX_BYTE:
                begin
                    if (link.scl_fall)
                    begin
                        armed <= 1'b1;
                        // msb first, line released in the ack slot
                        if (bit_cnt < eeprom_cfg_pkg::ACK_SLOT)
                            link.sda_low <= ~shreg[7];
                        else
                            link.sda_low <= 1'b0;
                    end
                    else if (link.scl_rise && armed)
                    begin
                        if (bit_cnt == eeprom_cfg_pkg::ACK_SLOT)
                        begin
                            link.ack_bit <= link.sda;
                            link.done    <= 1'b1;
                            state        <= TX_IDLE;
                        end
                        else
                        begin
                            shreg   <= {shreg[6:0], 1'b0};
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

/* eeprom_cfg_pkg.sv */
package eeprom_cfg_pkg;

    // memory geometry
    localparam int ADDR_W = 11;
    localparam int BYTE_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [BYTE_W-1:0] byte_t;

    // control byte is {DEVICE_CODE, addr[10:8], rw}
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    // level on sda during the ninth clock
    localparam logic ACK_LEVEL  = 1'b0;
    localparam logic NACK_LEVEL = 1'b1;

    // bit counter value of the acknowledge slot
    localparam logic [3:0] ACK_SLOT = 4'(BYTE_W);

endpackage

/* eeprom_master.sv */
module eeprom_master #(
    parameter int HALF_PERIOD = 4
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr_req,
    input  logic                  rd_req,
    input  eeprom_cfg_pkg::addr_t addr,
    input  eeprom_cfg_pkg::byte_t wdata,
    output logic                  busy,
    output logic                  done,
    output eeprom_cfg_pkg::byte_t rdata,
    output logic                  nack,
    output logic                  scl,
    output logic                  sda_low,
    input  logic                  sda_in
);

    shift_if tx_link ();
    shift_if rx_link ();

    eeprom_sequencer #(
        .HALF_PERIOD (HALF_PERIOD)
    ) u_sequencer (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr_req  (wr_req),
        .rd_req  (rd_req),
        .addr    (addr),
        .wdata   (wdata),
        .busy    (busy),
        .done    (done),
        .nack    (nack),
        .rdata   (rdata),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda_in),
        .tx_link (tx_link.seq),
        .rx_link (rx_link.seq)
    );

    byte_transmitter u_transmitter (
        .CLK   (CLK),
        .RESET (RESET),
        .link  (tx_link.tx)
    );

    byte_receiver u_receiver (
        .CLK   (CLK),
        .RESET (RESET),
        .link  (rx_link.rx)
    );

endmodule

/* eeprom_sequencer.sv */
module eeprom_sequencer #(
    parameter int HALF_PERIOD = 4
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr_req,
    input  logic                  rd_req,
    input  eeprom_cfg_pkg::addr_t addr,
    input  eeprom_cfg_pkg::byte_t wdata,
    output logic                  busy,
    output logic                  done,
    output logic                  nack,
    output eeprom_cfg_pkg::byte_t rdata,
    output logic                  scl,
    output logic                  sda_low,
    input  logic                  sda_in,
    shift_if.seq                  tx_link,
    shift_if.seq                  rx_link
);

    localparam int CNT_W = $clog2(HALF_PERIOD) + 1;

    serial_frame_pkg::seq_state_e state;
    logic [CNT_W-1:0]             half_cnt;
    logic                         scl_rise;
    logic                         scl_fall;
    logic                         scl_run;
    logic                         is_read;
    logic                         tx_nak;
    eeprom_cfg_pkg::addr_t        addr_q;
    eeprom_cfg_pkg::byte_t        wdata_q;

    function automatic eeprom_cfg_pkg::byte_t ctrl_byte(input logic rw);
        return {eeprom_cfg_pkg::DEVICE_CODE, addr_q[eeprom_cfg_pkg::ADDR_W-1:8], rw};
    endfunction

    // scl only toggles inside a frame
    assign scl_run = (state != serial_frame_pkg::S_IDLE) && (state != serial_frame_pkg::S_DONE);

    always_ff @(posedge CLK)
    begin
        if (RESET || !scl_run)
        begin
            half_cnt <= '0;
            scl      <= 1'b1;
            scl_rise <= 1'b0;
            scl_fall <= 1'b0;
        end
        else if (half_cnt == CNT_W'(HALF_PERIOD - 1))
        begin
            half_cnt <= '0;
            scl      <= ~scl;
            scl_rise <= ~scl;
            scl_fall <= scl;
        end
        else
        begin
            half_cnt <= half_cnt + 1'b1;
            scl_rise <= 1'b0;
            scl_fall <= 1'b0;
        end
    end

    assign tx_link.scl_rise = scl_rise;
    assign tx_link.scl_fall = scl_fall;
    assign tx_link.sda      = sda_in;
    assign rx_link.scl_rise = scl_rise;
    assign rx_link.scl_fall = scl_fall;
    assign rx_link.sda      = sda_in;
    // single read is always closed with not-acknowledge
    assign rx_link.tx_byte  = {7'd0, eeprom_cfg_pkg::NACK_LEVEL};

    assign sda_low = tx_link.sda_low | rx_link.sda_low;  // wired-and on the bus
    assign tx_nak  = (tx_link.ack_bit == eeprom_cfg_pkg::NACK_LEVEL);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= serial_frame_pkg::S_IDLE;
            busy       <= 1'b0;
            done       <= 1'b0;
            nack       <= 1'b0;
            is_read    <= 1'b0;
            tx_link.go <= 1'b0;
            rx_link.go <= 1'b0;
        end
        else
        begin
            done       <= 1'b0;
            tx_link.go <= 1'b0;
            rx_link.go <= 1'b0;
            case (state)
                serial_frame_pkg::S_IDLE:
                begin
                    if (wr_req || rd_req)
                    begin
                        is_read     <= !wr_req;  // write wins
                        addr_q      <= addr;
                        wdata_q     <= wdata;
                        busy        <= 1'b1;
                        nack        <= 1'b0;
                        tx_link.go  <= 1'b1;
                        tx_link.cmd <= serial_frame_pkg::CMD_START;
                        state       <= serial_frame_pkg::S_START;
                    end
                end
                serial_frame_pkg::S_START:
                begin
                    if (tx_link.done)
                    begin
                        tx_link.go      <= 1'b1;
                        tx_link.cmd     <= serial_frame_pkg::CMD_BYTE;
                        tx_link.tx_byte <= ctrl_byte(eeprom_cfg_pkg::RW_WRITE);
                        state           <= serial_frame_pkg::S_CTRL_WR;
                    end
                end
                serial_frame_pkg::S_CTRL_WR, serial_frame_pkg::S_ADDR,
                serial_frame_pkg::S_DATA_WR, serial_frame_pkg::S_CTRL_RD:
                begin
                    if (tx_link.done)
                    begin
                        tx_link.go <= 1'b1;
                        if (tx_nak || state == serial_frame_pkg::S_DATA_WR)
                        begin
                            nack        <= tx_nak;  // missing ack goes straight to stop
                            tx_link.cmd <= serial_frame_pkg::CMD_STOP;
                            state       <= serial_frame_pkg::S_STOP;
                        end
                        else if (state == serial_frame_pkg::S_CTRL_WR)
                        begin
                            tx_link.cmd     <= serial_frame_pkg::CMD_BYTE;
                            tx_link.tx_byte <= addr_q[7:0];
                            state           <= serial_frame_pkg::S_ADDR;
                        end
                        else if (state == serial_frame_pkg::S_CTRL_RD)
                        begin
                            tx_link.go <= 1'b0;
                            rx_link.go <= 1'b1;
                            state      <= serial_frame_pkg::S_DATA_RD;
                        end
                        else if (is_read)
                        begin
                            tx_link.cmd <= serial_frame_pkg::CMD_START;
                            state       <= serial_frame_pkg::S_RESTART;
                        end
                        else
                        begin
                            tx_link.cmd     <= serial_frame_pkg::CMD_BYTE;
                            tx_link.tx_byte <= wdata_q;
                            state           <= serial_frame_pkg::S_DATA_WR;
                        end
                    end
                end
                serial_frame_pkg::S_RESTART:
                begin
                    if (tx_link.done)
                    begin
                        tx_link.go      <= 1'b1;
                        tx_link.cmd     <= serial_frame_pkg::CMD_BYTE;
                        tx_link.tx_byte <= ctrl_byte(eeprom_cfg_pkg::RW_READ);
                        state           <= serial_frame_pkg::S_CTRL_RD;
                    end
                end
                serial_frame_pkg::S_DATA_RD:
                begin
                    if (rx_link.done)
                    begin
                        rdata       <= rx_link.rx_byte;
                        tx_link.go  <= 1'b1;
                        tx_link.cmd <= serial_frame_pkg::CMD_STOP;
                        state       <= serial_frame_pkg::S_STOP;
                    end
                end
                serial_frame_pkg::S_STOP:
                begin
                    if (tx_link.done)
                        state <= serial_frame_pkg::S_DONE;
                end
                serial_frame_pkg::S_DONE:
                begin
                    done  <= 1'b1;
                    busy  <= 1'b0;
                    state <= serial_frame_pkg::S_IDLE;
                end
                default: state <= serial_frame_pkg::S_IDLE;
            endcase
        end
    end

endmodule

/* eeprom_testdata.txt */
# op (W write, R read, D read with a second strobe while busy), addr, data,
# expected read value (hex), device present (1) or absent (0)
R 005 00 26 1
R 7FF 00 FC 1
R 100 00 03 1
W 123 A5 00 1
R 123 00 A5 1
W 124 5A 00 1
R 123 00 A5 1
R 124 00 5A 1
W 200 77 00 0
R 200 00 03 1
R 0FF 00 00 0
D 2AB 00 B0 1
W 2AB 00 00 1
R 2AB 00 00 1
W 7FF 3C 00 1
R 7FF 00 3C 1
R 000 00 03 1

/* serial_frame_pkg.sv */
package serial_frame_pkg;

    // what the transmitter does on its next go
    typedef enum logic [1:0] {
        CMD_START = 2'd0,
        CMD_STOP  = 2'd1,
        CMD_BYTE  = 2'd2
    } bit_cmd_e;

    // position of the sequencer inside one frame
    typedef enum logic [3:0] {
        S_IDLE     = 4'd0,
        S_START    = 4'd1,
        S_CTRL_WR  = 4'd2,
        S_ADDR     = 4'd3,
        S_DATA_WR  = 4'd4,
        S_RESTART  = 4'd5,
        S_CTRL_RD  = 4'd6,
        S_DATA_RD  = 4'd7,
        S_STOP     = 4'd8,
        S_DONE     = 4'd9
    } seq_state_e;

endpackage

/* shift_if.sv */
interface shift_if;

    logic                       go;        // one-cycle request
    serial_frame_pkg::bit_cmd_e cmd;
    eeprom_cfg_pkg::byte_t      tx_byte;   // receiver takes its ack level from bit 0
    logic                       scl_rise;
    logic                       scl_fall;
    logic                       sda;       // sensed line
    logic                       done;
    logic                       sda_low;   // engine pulls the line low
    eeprom_cfg_pkg::byte_t      rx_byte;
    logic                       ack_bit;

    modport seq (
        output go, cmd, tx_byte, scl_rise, scl_fall, sda,
        input  done, sda_low, rx_byte, ack_bit
    );

    modport tx (
        input  go, cmd, tx_byte, scl_rise, scl_fall, sda,
        output done, sda_low, rx_byte, ack_bit
    );

    modport rx (
        input  go, tx_byte, scl_rise, scl_fall, sda,
        output done, sda_low, rx_byte, ack_bit
    );

endinterface

/* sources.f */
eeprom_cfg_pkg.sv
serial_frame_pkg.sv
shift_if.sv
byte_transmitter.sv
byte_receiver.sv
eeprom_sequencer.sv
eeprom_master.sv
tb_eeprom_model.sv
tb_eeprom_master.sv

/* tb_eeprom_master.sv */
module tb_eeprom_master;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 4;

    logic                  CLK = 1'b0;
    logic                  RESET;
    logic                  wr_req;
    logic                  rd_req;
    eeprom_cfg_pkg::addr_t addr;
    eeprom_cfg_pkg::byte_t wdata;
    logic                  busy;
    logic                  done;
    eeprom_cfg_pkg::byte_t rdata;
    logic                  nack;
    logic                  scl;
    logic                  sda_low;
    logic                  sda_in;
    logic                  present;
    int                    model_errors;
    int                    done_cnt;
    int                    n_tests = 0;

    byte op_q[$];
    int  addr_q[$];
    int  data_q[$];
    int  exp_q[$];
    int  pres_q[$];

    always #2 CLK = ~CLK;

    eeprom_master #(
        .HALF_PERIOD (HALF_PERIOD)
    ) u_dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr_req  (wr_req),
        .rd_req  (rd_req),
        .addr    (addr),
        .wdata   (wdata),
        .busy    (busy),
        .done    (done),
        .rdata   (rdata),
        .nack    (nack),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda_in)
    );

    tb_eeprom_model u_model (
        .scl     (scl),
        .sda_low (sda_low),
        .present (present),
        .sda     (sda_in),
        .errors  (model_errors)
    );

    always @(negedge CLK)
    begin
        if (RESET)
            done_cnt <= 0;
        else if (done)
            done_cnt <= done_cnt + 1;
    end

    // budget of 40 scl periods per test
    initial
    begin
        wait (n_tests > 0);
        #((n_tests * 40 * HALF_PERIOD * 2 + 8) * 4);
        $display("watchdog expired, a request never finished");
        $display("TEST FAILED");
        $finish;
    end

    function automatic int load_tests();
        int    fd;
        int    r;
        int    a;
        int    d;
        int    e;
        int    p;
        string line;
        string op;
        fd = $fopen("eeprom_testdata.txt", "r");
        if (fd == 0)
            return 0;
        while (!$feof(fd))
        begin
            r = $fgets(line, fd);
            if (r > 0 && line.len() > 1 && line[0] != 8'h23)
            begin
                r = $sscanf(line, "%s %h %h %h %d", op, a, d, e, p);
                if (r == 5)
                begin
                    op_q.push_back(op[0]);
                    addr_q.push_back(a);
                    data_q.push_back(d);
                    exp_q.push_back(e);
                    pres_q.push_back(p);
                end
            end
        end
        $fclose(fd);
        return op_q.size();
    endfunction

    task automatic run_test(input int idx, output logic bad);
        int  before_done;
        int  before_err;
        byte op;
        op          = op_q[idx];
        bad         = 1'b0;
        before_done = done_cnt;
        before_err  = model_errors;
        @(posedge CLK);
        present <= (pres_q[idx] != 0);
        addr    <= eeprom_cfg_pkg::addr_t'(addr_q[idx]);
        wdata   <= eeprom_cfg_pkg::byte_t'(data_q[idx]);
        if (op == "W")
            wr_req <= 1'b1;
        else
            rd_req <= 1'b1;
        @(posedge CLK);
        wr_req <= 1'b0;
        rd_req <= 1'b0;
        if (op == "D")
        begin
            repeat (HALF_PERIOD * 4) @(posedge CLK);
            if (busy !== 1'b1)
            begin
                $display("FAILED test %0d: busy got 0x%h expected 0x1", idx, busy);
                bad = 1'b1;
            end
            rd_req <= 1'b1;
            @(posedge CLK);
            rd_req <= 1'b0;
        end
        @(negedge CLK);
        while (!done)
            @(negedge CLK);
        if (busy !== 1'b0)
        begin
            $display("FAILED test %0d: busy got 0x%h expected 0x0", idx, busy);
            bad = 1'b1;
        end
        if (nack !== (pres_q[idx] == 0))
        begin
            $display("FAILED test %0d: nack got 0x%h expected 0x%h", idx, nack, pres_q[idx] == 0);
            bad = 1'b1;
        end
        if (op != "W" && pres_q[idx] != 0 && rdata !== eeprom_cfg_pkg::byte_t'(exp_q[idx]))
        begin
            $display("FAILED test %0d: rdata got 0x%h expected 0x%h", idx, rdata,
                     eeprom_cfg_pkg::byte_t'(exp_q[idx]));
            bad = 1'b1;
        end
        repeat (HALF_PERIOD * 4) @(negedge CLK);
        if (done_cnt - before_done != 1)
        begin
            $display("FAILED test %0d: done_cnt got 0x%h expected 0x1", idx, done_cnt - before_done);
            bad = 1'b1;
        end
        if (model_errors != before_err)
        begin
            $display("test %0d: the memory model saw a protocol error", idx);
            bad = 1'b1;
        end
        if (!bad)
            $display("test %0d %c addr 0x%h: ok", idx, op, addr_q[idx]);
    endtask

    initial
    begin
        int   n;
        int   fails;
        logic bad;
        RESET   = 1'b1;
        wr_req  = 1'b0;
        rd_req  = 1'b0;
        addr    = '0;
        wdata   = '0;
        present = 1'b1;
        fails   = 0;
        n = load_tests();
        if (n == 0)
        begin
            $display("no tests could be read from eeprom_testdata.txt");
            $display("TEST FAILED");
            $finish;
        end
        else
        begin
            n_tests = n;
            repeat (8) @(posedge CLK);
            RESET <= 1'b0;
            repeat (2) @(negedge CLK);
            if (scl !== 1'b1 || sda_low !== 1'b0 || busy !== 1'b0 || done !== 1'b0)
            begin
                $display("FAILED reset: scl/sda_low/busy/done got 0x%h expected 0x8",
                         {scl, sda_low, busy, done});
                fails++;
            end
            else
                $display("reset values: ok");
            for (int i = 0; i < n; i++)
            begin
                run_test(i, bad);
                if (bad)
                    fails++;
            end
            $display("tests run %0d, passed %0d, failed %0d, model errors %0d",
                     n + 1, n + 1 - fails, fails, model_errors);
            if (fails == 0 && model_errors == 0)
                $display("TEST OK");
            else
                $display("TEST FAILED");
            $finish;
        end
    end

endmodule

/* tb_eeprom_model.sv */
module tb_eeprom_model (
    input  logic scl,
    input  logic sda_low,   // master pulls the line low
    input  logic present,   // 0 = device never acknowledges
    output logic sda,
    output int   errors
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int P_IDLE       = 0;
    localparam int P_CTRL_WR    = 1;
    localparam int P_ADDR       = 2;
    localparam int P_AFTER_ADDR = 3;  // data byte or repeated start
    localparam int P_CTRL_RD    = 4;
    localparam int P_DATA_RD    = 5;
    localparam int P_WAIT_STOP  = 6;

    logic [7:0]  mem [0:2047];
    int          phase = P_IDLE;
    int          next_phase = P_IDLE;
    int          bit_cnt = 0;
    int          err_cnt = 0;
    logic [7:0]  shreg = 8'h00;
    logic [7:0]  rdbuf = 8'h00;
    logic [7:0]  wbuf = 8'h00;
    logic [2:0]  hi = 3'd0;
    logic [10:0] ptr = 11'd0;
    logic        wpend = 1'b0;
    logic        ack_pend = 1'b0;
    logic        slave_low = 1'b0;
    logic        scl_prev = 1'b1;
    logic        sda_prev = 1'b1;

    assign sda    = ~(sda_low | slave_low);  // open drain bus
    assign errors = err_cnt;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'((i * 7 + 3) % 256);
    end

    task automatic protocol_error(input string msg);
        err_cnt++;
        $display("eeprom model: %s", msg);
    endtask

    // called once the eighth bit of a master byte is in
    task automatic take_byte();
        case (phase)
            P_CTRL_WR:
            begin
                if (shreg[7:4] != eeprom_cfg_pkg::DEVICE_CODE || shreg[0] != 1'b0)
                    protocol_error($sformatf("control byte %h is not a write control", shreg));
                hi         = shreg[3:1];
                next_phase = P_ADDR;
            end
            P_ADDR:
            begin
                ptr        = {hi, shreg};
                next_phase = P_AFTER_ADDR;
            end
            P_AFTER_ADDR:
            begin
                wbuf       = shreg;
                wpend      = present;  // committed at stop
                next_phase = P_WAIT_STOP;
            end
            default:
            begin
                if (shreg != {eeprom_cfg_pkg::DEVICE_CODE, hi, 1'b1})
                    protocol_error($sformatf("read control byte %h does not match", shreg));
                next_phase = P_DATA_RD;
            end
        endcase
        ack_pend = present;
        if (!present)
            next_phase = P_WAIT_STOP;
    endtask

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b1 && sda === 1'b0)
        begin
            if (phase == P_AFTER_ADDR && bit_cnt <= 1)
                phase = P_CTRL_RD;  // repeated start
            else if (phase == P_IDLE)
                phase = P_CTRL_WR;
            else
            begin
                protocol_error("start condition in the middle of a frame");
                phase = P_CTRL_WR;
            end
            bit_cnt  = 0;
            ack_pend = 1'b0;
        end
        else if (scl === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b0 && sda === 1'b1)
        begin
            if (phase != P_IDLE)
            begin
                if (phase != P_WAIT_STOP)
                    protocol_error("stop condition before the frame was complete");
                if (wpend)
                    mem[ptr] = wbuf;
                wpend = 1'b0;
                phase = P_IDLE;
            end
        end
        else if (scl === 1'b1 && scl_prev === 1'b0)
        begin
            if (phase != P_IDLE && phase != P_WAIT_STOP)
            begin
                if (bit_cnt < 8)
                begin
                    if (phase == P_DATA_RD)
                        rdbuf = {rdbuf[6:0], 1'b0};
                    else
                        shreg = {shreg[6:0], sda};
                    bit_cnt++;
                    if (bit_cnt == 8 && phase != P_DATA_RD)
                        take_byte();
                end
                else
                begin
                    bit_cnt  = 0;
                    ack_pend = 1'b0;
                    if (phase == P_DATA_RD)
                    begin
                        if (sda !== 1'b1)
                            protocol_error("master acknowledged the read byte");
                        phase = P_WAIT_STOP;
                    end
                    else
                    begin
                        phase = next_phase;
                        rdbuf = mem[ptr];
                    end
                end
            end
        end
        else if (scl === 1'b0 && scl_prev === 1'b1)
        begin
            if (phase == P_DATA_RD && bit_cnt < 8)
                slave_low = ~rdbuf[7];
            else
                slave_low = ack_pend;
        end
        scl_prev = scl;
        sda_prev = sda;
    end

endmodule
